/* ppu_pkg.sv */
package ppu_pkg;

  // Posit format. The design is built for 16-bit posits with one exponent bit.
  localparam int N = 16;
  localparam int ES = 1;

  // The signed total exponent is the regime value times 2^ES plus the exponent bits.
  localparam int TE_SIZE = 7;

  // Hidden bit plus fraction bits.
  localparam int MANT_SIZE = 14;

  // Alignment shifts beyond this distance drop the shifted bits.
  localparam int MAX_TE_DIFF = 14;

  // Aligned sum keeps one carry bit above the upshifted mantissa.
  localparam int MANT_ADD_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF + 1;
  localparam int MANT_SUB_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF;

  // Largest total exponent of a posit; minpos sits at the negated value.
  localparam int TE_MAX = (N - 2) * (1 << ES);

  // Working width of the encoder shifter.
  localparam int ENC_SIZE = 3 * N;

  localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

  // Wishbone addresses.
  localparam logic ADR_ADD = 1'b0;
  localparam logic ADR_SUB = 1'b1;

  function automatic logic signed [TE_SIZE-1:0] max(
    input logic signed [TE_SIZE-1:0] a,
    input logic signed [TE_SIZE-1:0] b
  );
    return (a > b) ? a : b;
  endfunction

endpackage : ppu_pkg

/* posit_if.sv */
`timescale 1ns/1ps

// One decoded operand.
interface decoded_if import ppu_pkg::*; ();
  logic                        sign;
  logic signed [TE_SIZE-1:0]   te;
  logic        [MANT_SIZE-1:0] mant;
  logic                        is_zero;
  logic                        is_nar;

  modport src (output sign, te, mant, is_zero, is_nar);
  modport dst (input sign, te, mant, is_zero, is_nar);
endinterface : decoded_if

// Normalized sum ahead of the encoder.
interface result_if import ppu_pkg::*; ();
  logic                                   sign;
  logic signed [TE_SIZE-1:0]              te;
  logic        [MANT_ADD_RESULT_SIZE-1:0] mant;
  logic                                   frac_truncated;
  logic                                   is_zero;
  logic                                   is_nar;

  modport src (output sign, te, mant, frac_truncated, is_zero, is_nar);
  modport dst (input sign, te, mant, frac_truncated, is_zero, is_nar);
endinterface : result_if

/* posit_decode.sv */
`timescale 1ns/1ps

module posit_decode import ppu_pkg::*; (
  input  logic [N-1:0] p,
  decoded_if.src       dec
);

  logic        [N-1:0]   abs_p;
  logic        [N-2:0]   body;
  logic                  r0;
  logic        [TE_SIZE-1:0] run;
  logic                  done;
  logic signed [TE_SIZE-1:0] k;
  logic        [N-2:0]   rem;

  assign dec.is_zero = (p == '0);
  assign dec.is_nar  = (p == NAR);
  assign dec.sign    = p[N-1];

  // Negative posits are decoded from their two's complement.
  assign abs_p = p[N-1] ? -p : p;
  assign body  = abs_p[N-2:0];
  assign r0    = body[N-2];

  // Length of the regime run, starting at the bit below the sign.
  always_comb begin
    run  = TE_SIZE'(1);
    done = 1'b0;
    for (int i = N - 3; i >= 0; i--) begin
      if (!done && body[i] == r0) begin
        run = run + 1'b1;
      end else begin
        done = 1'b1;
      end
    end
  end

  assign k = r0 ? run - 1'b1 : -run;

  // Drop the regime and its terminating bit, leaving exponent then fraction.
  assign rem = body << (run + 1'b1);

  assign dec.te   = {k[TE_SIZE-1-ES:0], rem[N-2 -: ES]};
  assign dec.mant = {1'b1, rem[N-2-ES -: MANT_SIZE-1]};

endmodule : posit_decode

/* core_add.sv */
`timescale 1ns/1ps

module core_add import ppu_pkg::*; (
  input  logic [MANT_ADD_RESULT_SIZE-1:0] mant,
  input  logic [TE_SIZE-1:0]              te_diff,
  output logic [MANT_ADD_RESULT_SIZE-1:0] new_mant,
  output logic [TE_SIZE-1:0]              new_te_diff,
  output logic                            frac_truncated
);

  // A same-sign sum can only overflow by one bit position.
  always_comb begin
    if (mant[MANT_ADD_RESULT_SIZE-1]) begin
      new_mant       = mant >> 1;
      new_te_diff    = te_diff + 1'b1;
      frac_truncated = mant[0];
    end else begin
      new_mant       = mant;
      new_te_diff    = te_diff;
      frac_truncated = 1'b0;
    end
  end

endmodule : core_add

/* core_sub.sv */
`timescale 1ns/1ps

module core_sub import ppu_pkg::*; (
  input  logic [MANT_SUB_RESULT_SIZE-1:0] mant,
  input  logic [TE_SIZE-1:0]              te_diff,
  output logic [MANT_SUB_RESULT_SIZE-1:0] new_mant,
  output logic [TE_SIZE-1:0]              new_te_diff
);

  logic [TE_SIZE-1:0] lz;
  logic               found;

  // Priority count of leading zeros from the top bit down.
  always_comb begin
    lz    = '0;
    found = 1'b0;
    for (int i = MANT_SUB_RESULT_SIZE - 1; i >= 0; i--) begin
      if (!found && !mant[i]) begin
        lz = lz + 1'b1;
      end else begin
        found = 1'b1;
      end
    end
  end

  // Bring the leading one back to the hidden-bit position.
  assign new_mant    = mant << lz;
  assign new_te_diff = te_diff - lz;

endmodule : core_sub

/* core_add_sub.sv */
`timescale 1ns/1ps

module core_add_sub import ppu_pkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [TE_SIZE-1:0]              te1_in,
  input  logic [TE_SIZE-1:0]              te2_in,
  input  logic [MANT_SIZE-1:0]            mant1_in,
  input  logic [MANT_SIZE-1:0]            mant2_in,
  input  logic                            have_opposite_sign,
  output logic [MANT_ADD_RESULT_SIZE-1:0] mant_out,
  output logic [TE_SIZE-1:0]              te_out,
  output logic                            frac_truncated
);

  logic signed [TE_SIZE-1:0]              te_diff_st0;
  logic        [TE_SIZE-1:0]              te_diff_st1;
  logic        [TE_SIZE-1:0]              te2_st1;
  logic                                   opposite_st1;
  logic        [MANT_SUB_RESULT_SIZE-1:0] mant1_up;
  logic        [MANT_SUB_RESULT_SIZE-1:0] mant2_up;
  logic        [MANT_SUB_RESULT_SIZE-1:0] mant2_eff;
  logic        [MANT_ADD_RESULT_SIZE-1:0] mant_sum_st0;
  logic        [MANT_ADD_RESULT_SIZE-1:0] mant_sum_st1;
  logic        [MANT_ADD_RESULT_SIZE-1:0] add_mant;
  logic        [TE_SIZE-1:0]              add_te_diff;
  logic        [MANT_SUB_RESULT_SIZE-1:0] sub_mant;
  logic        [TE_SIZE-1:0]              sub_te_diff;

  assign te_diff_st0 = $signed(te1_in) - $signed(te2_in);

  // The smaller operand moves right by the exponent difference.
  assign mant1_up  = mant1_in << MAX_TE_DIFF;
  assign mant2_up  = (mant2_in << MAX_TE_DIFF) >> max(0, te_diff_st0);
  assign mant2_eff = have_opposite_sign ? -mant2_up : mant2_up;

  assign mant_sum_st0 = {1'b0, mant1_up} + {1'b0, mant2_eff};

  always_ff @(posedge clk) begin
    if (rst) begin
      te_diff_st1  <= '0;
      mant_sum_st1 <= '0;
      opposite_st1 <= 1'b0;
      te2_st1      <= '0;
    end else begin
      te_diff_st1  <= te_diff_st0;
      mant_sum_st1 <= mant_sum_st0;
      opposite_st1 <= have_opposite_sign;
      te2_st1      <= te2_in;
    end
  end

  core_add u_core_add (
    .mant           (mant_sum_st1),
    .te_diff        (te_diff_st1),
    .new_mant       (add_mant),
    .new_te_diff    (add_te_diff),
    .frac_truncated (frac_truncated)
  );

  // The carry bit of a difference is meaningless and is not passed on.
  core_sub u_core_sub (
    .mant        (mant_sum_st1[MANT_SUB_RESULT_SIZE-1:0]),
    .te_diff     (te_diff_st1),
    .new_mant    (sub_mant),
    .new_te_diff (sub_te_diff)
  );

  assign mant_out = opposite_st1 ? {1'b0, sub_mant} : add_mant;
  assign te_out   = te2_st1 + (opposite_st1 ? sub_te_diff : add_te_diff);

endmodule : core_add_sub

/* posit_execute.sv */
`timescale 1ns/1ps

module posit_execute import ppu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  decoded_if.dst a,
  decoded_if.dst b,
  result_if.src  res
);

  logic [MANT_SIZE-1:0] mant_a;
  logic [MANT_SIZE-1:0] mant_b;
  logic                 a_larger;
  logic                 have_opposite_sign;
  logic                 cancel;
  logic                 sign_st1;
  logic                 zero_st1;
  logic                 nar_st1;

  // A zero operand enters the core with an empty mantissa, so the other
  // operand comes out unchanged.
  assign mant_a = a.is_zero ? '0 : a.mant;
  assign mant_b = b.is_zero ? '0 : b.mant;

  assign a_larger = (a.te > b.te) || ((a.te == b.te) && (mant_a >= mant_b));

  assign have_opposite_sign = a.sign ^ b.sign;

  assign cancel = have_opposite_sign && (a.te == b.te) && (mant_a == mant_b);

  always_ff @(posedge clk) begin
    if (rst) begin
      sign_st1 <= 1'b0;
      zero_st1 <= 1'b0;
      nar_st1  <= 1'b0;
    end else begin
      sign_st1 <= a_larger ? a.sign : b.sign;
      zero_st1 <= (a.is_zero && b.is_zero) || cancel;
      nar_st1  <= a.is_nar || b.is_nar;
    end
  end

  core_add_sub u_core_add_sub (
    .clk                (clk),
    .rst                (rst),
    .te1_in             (a_larger ? a.te : b.te),
    .te2_in             (a_larger ? b.te : a.te),
    .mant1_in           (a_larger ? mant_a : mant_b),
    .mant2_in           (a_larger ? mant_b : mant_a),
    .have_opposite_sign (have_opposite_sign),
    .mant_out           (res.mant),
    .te_out             (res.te),
    .frac_truncated     (res.frac_truncated)
  );

  assign res.sign    = sign_st1;
  assign res.is_zero = zero_st1;
  assign res.is_nar  = nar_st1;

endmodule : posit_execute

/* posit_encode.sv */
`timescale 1ns/1ps

module posit_encode import ppu_pkg::*; (
  result_if.dst        res,
  output logic [N-1:0] p
);

  logic                       too_big;
  logic                       too_small;
  logic signed [TE_SIZE-1:0]  k;
  logic        [ES-1:0]       exp_bits;
  logic        [TE_SIZE-1:0]  shamt;
  logic signed [ENC_SIZE-1:0] seed;
  logic signed [ENC_SIZE-1:0] shifted;
  logic        [N-2:0]        body;
  logic                       guard;
  logic                       sticky;
  logic                       round_up;
  logic        [N-2:0]        body_rounded;
  logic        [N-2:0]        mag;

  // Results outside the posit range saturate to maxpos or minpos.
  assign too_big   = res.te > TE_MAX;
  assign too_small = res.te < -TE_MAX;

  assign k        = res.te >>> ES;
  assign exp_bits = res.te[ES-1:0];

  // The arithmetic shift fills the regime with copies of its leading bit.
  // A positive regime starts from 10, a negative one from 01.
  assign seed = k[TE_SIZE-1]
    ? {2'b01, exp_bits, res.mant[MANT_ADD_RESULT_SIZE-3:0],
       {(ENC_SIZE-MANT_ADD_RESULT_SIZE-ES){1'b0}}}
    : {2'b10, exp_bits, res.mant[MANT_ADD_RESULT_SIZE-3:0],
       {(ENC_SIZE-MANT_ADD_RESULT_SIZE-ES){1'b0}}};

  assign shamt = k[TE_SIZE-1] ? -k - 1'b1 : k;

  assign shifted = seed >>> shamt;

  assign body   = shifted[ENC_SIZE-1 -: N-1];
  assign guard  = shifted[ENC_SIZE-N];
  assign sticky = (|shifted[ENC_SIZE-N-1:0]) | res.frac_truncated;

  // Round to nearest, ties to the even pattern.
  assign round_up     = guard & (body[0] | sticky);
  assign body_rounded = body + round_up;

  always_comb begin
    if (too_big) begin
      mag = '1;
    end else if (too_small) begin
      mag = (N-1)'(1);
    end else begin
      mag = body_rounded;
    end
  end

  always_comb begin
    if (res.is_nar) begin
      p = NAR;
    end else if (res.is_zero) begin
      p = '0;
    end else if (res.sign) begin
      p = -{1'b0, mag};
    end else begin
      p = {1'b0, mag};
    end
  end

endmodule : posit_encode

/* posit_adder_wb.sv */
`timescale 1ns/1ps

module posit_adder_wb import ppu_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  logic           cyc,
  input  logic           stb,
  input  logic           we,
  input  logic           adr,
  input  logic [2*N-1:0] dat_w,
  output logic [2*N-1:0] dat_r,
  output logic           ack
);

  logic [N-1:0] op_a;
  logic [N-1:0] op_b;
  logic [N-1:0] result;
  logic [N-1:0] sum_p;
  logic [1:0]   stage;
  logic         req;

  decoded_if dec_a ();
  decoded_if dec_b ();
  result_if  res ();

  // Requests are taken only when no operation is in flight.
  assign req = cyc && stb && !ack && (stage == 2'd0);

  always_ff @(posedge clk) begin
    if (req && we) begin
      op_a <= dat_w[N-1:0];
      case (adr)
        ADR_ADD: op_b <= dat_w[2*N-1:N];
        ADR_SUB: op_b <= -dat_w[2*N-1:N];
      endcase
    end
  end

  // Stage 1 waits for the core register, stage 2 loads the encoded result.
  always_ff @(posedge clk) begin
    if (rst) begin
      stage  <= 2'd0;
      ack    <= 1'b0;
      result <= '0;
    end else begin
      ack <= 1'b0;
      case (stage)
        2'd0: begin
          if (req && we) begin
            stage <= 2'd1;
          end else if (req) begin
            ack <= 1'b1;
          end
        end
        2'd1: stage <= 2'd2;
        default: begin
          result <= sum_p;
          ack    <= 1'b1;
          stage  <= 2'd0;
        end
      endcase
    end
  end

  assign dat_r = {{N{1'b0}}, result};

  posit_decode u_dec_a (.p(op_a), .dec(dec_a));
  posit_decode u_dec_b (.p(op_b), .dec(dec_b));

  posit_execute u_execute (
    .clk (clk),
    .rst (rst),
    .a   (dec_a),
    .b   (dec_b),
    .res (res)
  );

  posit_encode u_encode (.res(res), .p(sum_p));

endmodule : posit_adder_wb

/* tb_posit_adder.sv */
`timescale 1ns/1ps

module tb_posit_adder import ppu_pkg::*;;

  localparam int ACK_LIMIT = 20;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic        adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic [31:0] lfsr_state;

  posit_adder_wb uut (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Galois LFSR that shifts right and applies the feedback taps when the low bit is one.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_posit(output logic [15:0] v);
    v = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    if (v == NAR) begin
      v = 16'h8001;
    end
  endtask

  function automatic logic [15:0] neg(input logic [15:0] v);
    return -v;
  endfunction

  // Waits for ack and returns how many rising edges followed the sampling edge.
  task automatic wait_ack(input string what, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!ack && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ack) begin
      $display("No ack seen on the %s within %0d cycles.", what, ACK_LIMIT);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // A write acks two edges after the sampling edge.
  task automatic wb_write(input logic addr, input logic [31:0] data);
    int cycles;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    dat_w = data;
    wait_ack("write", cycles);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    check("write ack latency", 32'd2, cycles);
    @(negedge clk);
    check("write ack width", 32'd0, {31'd0, ack});
  endtask

  task automatic wb_read(output logic [31:0] data);
    int cycles;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = ADR_ADD;
    wait_ack("read", cycles);
    data = dat_r;
    cyc  = 1'b0;
    stb  = 1'b0;
    check("read ack latency", 32'd0, cycles);
    @(negedge clk);
    check("read ack width", 32'd0, {31'd0, ack});
  endtask

  task automatic run_op(input logic sub, input logic [15:0] a, input logic [15:0] b,
                        output logic [15:0] r);
    logic [31:0] word;
    wb_write(sub ? ADR_SUB : ADR_ADD, {b, a});
    wb_read(word);
    check("upper read bits", 32'd0, {16'd0, word[31:16]});
    r = word[15:0];
  endtask

  task automatic test_bus_behavior();
    logic [31:0] first;
    logic [31:0] second;
    wb_read(first);
    check("read after reset", 32'd0, first);
    wb_write(ADR_ADD, {16'h3000, 16'h4000});
    wb_read(first);
    wb_read(second);
    check("first read", 32'h0000_4800, first);
    check("second read", 32'h0000_4800, second);
  endtask

  task automatic test_known_sums();
    logic [15:0] r;
    run_op(1'b0, 16'h4000, 16'h4000, r);
    check("1 + 1", 16'h5000, r);
    run_op(1'b0, 16'h4000, 16'h3000, r);
    check("1 + 0.5", 16'h4800, r);
    run_op(1'b0, 16'h5000, 16'h4000, r);
    check("2 + 1", 16'h5800, r);
    run_op(1'b1, 16'h5000, 16'h4000, r);
    check("2 - 1", 16'h4000, r);
    run_op(1'b1, 16'h4000, 16'h5000, r);
    check("1 - 2", 16'hC000, r);
  endtask

  task automatic test_special_values();
    logic [15:0] xs [5];
    logic [15:0] r;
    xs = '{16'h4000, 16'h5A3C, 16'hB123, 16'h0001, 16'h7FFF};
    foreach (xs[i]) begin
      run_op(1'b0, xs[i], 16'h0000, r);
      check("x + 0", xs[i], r);
      run_op(1'b0, 16'h0000, xs[i], r);
      check("0 + x", xs[i], r);
      run_op(1'b1, xs[i], xs[i], r);
      check("x - x", 16'h0000, r);
      run_op(1'b0, NAR, xs[i], r);
      check("NaR + x", NAR, r);
      run_op(1'b1, xs[i], NAR, r);
      check("x - NaR", NAR, r);
    end
    run_op(1'b0, NAR, 16'h0000, r);
    check("NaR + 0", NAR, r);
  endtask

  task automatic test_commutativity();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] ab;
    logic [15:0] ba;
    for (int i = 0; i < 40; i++) begin
      random_posit(a);
      random_posit(b);
      run_op(1'b0, a, b, ab);
      run_op(1'b0, b, a, ba);
      check("a + b vs b + a", ab, ba);
    end
  endtask

  task automatic test_sign_symmetry();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r1;
    logic [15:0] r2;
    for (int i = 0; i < 40; i++) begin
      random_posit(a);
      random_posit(b);
      run_op(1'b1, a, b, r1);
      run_op(1'b0, a, neg(b), r2);
      check("a - b vs a + neg b", r2, r1);
      run_op(1'b0, a, b, r1);
      run_op(1'b0, neg(a), neg(b), r2);
      check("neg a + neg b", neg(r1), r2);
    end
  endtask

  task automatic test_saturation();
    logic [15:0] r;
    run_op(1'b0, 16'h7FFF, 16'h7FFF, r);
    check("maxpos + maxpos", 16'h7FFF, r);
    run_op(1'b1, 16'h0001, 16'h0001, r);
    check("minpos - minpos", 16'h0000, r);
    run_op(1'b1, 16'h7FFF, 16'h4000, r);
    check("maxpos - 1", 16'h7FFF, r);
    run_op(1'b0, 16'h0001, 16'h0001, r);
    check("minpos + minpos", 16'h0002, r);
  endtask

  initial begin
    rst        = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = 1'b0;
    dat_w      = '0;
    lfsr_state = 32'h951a_4761;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // The reset read has to come before any write.
    test_bus_behavior();
    test_known_sums();
    test_special_values();
    test_commutativity();
    test_sign_symmetry();
    test_saturation();

    $display("sim passed");
    $finish;
  end

endmodule : tb_posit_adder

/* list.f */
ppu_pkg.sv
posit_if.sv
posit_decode.sv
core_add.sv
core_sub.sv
core_add_sub.sv
posit_execute.sv
posit_encode.sv
posit_adder_wb.sv
tb_posit_adder.sv
